// ==== hdl/dbg_apb_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module dbg_apb_regs (
	input wire clk,
	input wire reset,

	input wire dbg_pkg::apb_addr_t paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire dbg_pkg::word_t pwdata,
	output dbg_pkg::word_t prdata,
	output logic pready,
	output logic pslverr,

	input wire dbg_pkg::word_t led_data,

	output logic sel_override,
	output dbg_pkg::view_sel_t override_sel,
	output logic cnt_clear
);

	import dbg_pkg::*;

	logic access;
	logic wr_access;
	logic rd_access;
	logic wr_legal;
	logic rd_legal;
	word_t ctrl_word;

	////////////////////////////////////////////////////////////////////////////
	// Access decode
	////////////////////////////////////////////////////////////////////////////

	// No wait states, every access cycle completes
	assign access = psel && penable;

	assign wr_legal = (paddr == APB_CTRL) || (paddr == APB_CLEAR);
	assign rd_legal = (paddr == APB_CTRL) || (paddr == APB_VIEW);

	assign wr_access = access && pwrite && wr_legal;
	assign rd_access = access && !pwrite && rd_legal;

	assign pready  = access;
	assign pslverr = access && !(pwrite ? wr_legal : rd_legal);

	assign ctrl_word = {override_sel, 7'b0, sel_override};

	always_comb begin
		prdata = '0;
		if (rd_access) begin
			case (paddr)
				APB_CTRL: prdata = ctrl_word;
				APB_VIEW: prdata = led_data;
				default:  prdata = '0;
			endcase
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// CTRL register and clear pulse
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk) begin
		if (reset) begin
			sel_override <= 1'b0;
			override_sel <= '0;
			cnt_clear <= 1'b0;
		end else begin
			if (wr_access && paddr == APB_CTRL) begin
				sel_override <= pwdata[0];
				override_sel <= pwdata[15:8];
			end
			// Single cycle, counters zero on the following edge
			cnt_clear <= wr_access && (paddr == APB_CLEAR);
		end
	end

	// Bus protocol from the host side
	penable_needs_psel: assert property (
		@(posedge clk) disable iff (reset)
		penable |-> psel
	);

endmodule

`default_nettype wire

// ==== hdl/dbg_pkg.sv ====
`default_nettype none

`include "dbg_settings.svh"

package dbg_pkg;

	typedef logic [15:0] word_t;
	typedef logic [3:0] reg_addr_t;
	typedef logic [7:0] view_sel_t;
	typedef logic [`DBG_CNT_W-1:0] count_t;
	typedef logic [3:0] apb_addr_t;

	// Fixed LED view codes
	typedef enum view_sel_t {
		VIEW_STATUS    = 8'h00,
		VIEW_PC        = 8'h0F,
		VIEW_INST      = 8'h10,
		VIEW_MEM_LO    = 8'h2D,
		VIEW_MEM_HI    = 8'h2E,
		VIEW_FETCH_LO  = 8'h2F,
		VIEW_REG_LAST  = 8'h30,
		VIEW_REG_FIRST = 8'h3F,
		VIEW_FAIL_LO   = 8'h48,
		VIEW_FAIL_HI   = 8'h49
	} view_code_e;

	localparam apb_addr_t APB_CTRL  = 4'h0;
	localparam apb_addr_t APB_VIEW  = 4'h4;
	localparam apb_addr_t APB_CLEAR = 4'h8;

endpackage

`default_nettype wire

// ==== hdl/dbg_settings.svh ====
`ifndef DBG_SETTINGS_SVH
`define DBG_SETTINGS_SVH

////////////////////////////////////////////////////////////////////////////
// Debug subsystem sizes
////////////////////////////////////////////////////////////////////////////

// Registers mirrored by the shadow
// At most 16 since the write index is 4 bits
`define DBG_NUM_REGS 16

// Width of each event counter
// Views show the low and high 16-bit halves
`define DBG_CNT_W 32

`endif

// ==== hdl/dbg_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_settings.svh"

module dbg_top (
	input wire clk,
	input wire reset,
	input wire dbg_pkg::word_t sw,
	output dbg_pkg::word_t led_data,

	input wire reg_writable,
	input wire dbg_pkg::reg_addr_t reg_write_addr,
	input wire dbg_pkg::word_t reg_write_value,

	input wire dbg_pkg::word_t if_pc,
	input wire dbg_pkg::word_t if_inst,
	input wire inst_read_done,
	input wire mem_op,
	input wire mem_retry,
	input wire hold,
	input wire flush,
	input wire decoder_error,

	input wire dbg_pkg::apb_addr_t paddr,
	input wire psel,
	input wire penable,
	input wire pwrite,
	input wire dbg_pkg::word_t pwdata,
	output dbg_pkg::word_t prdata,
	output logic pready,
	output logic pslverr
);

	import dbg_pkg::*;

	logic [`DBG_NUM_REGS*$bits(word_t)-1:0] reg_debug_out;
	count_t mem_act;
	count_t fetch_cnt;
	count_t fail_cnt;
	logic sel_override;
	view_sel_t override_sel;
	logic cnt_clear;

	reg_shadow reg_shadow_inst (
		.clk(clk),
		.reset(reset),
		.reg_writable(reg_writable),
		.reg_write_addr(reg_write_addr),
		.reg_write_value(reg_write_value),
		.reg_debug_out(reg_debug_out)
	);

	event_counters event_counters_inst (
		.clk(clk),
		.reset(reset),
		.mem_op(mem_op),
		.inst_read_done(inst_read_done),
		.mem_retry(mem_retry),
		.cnt_clear(cnt_clear),
		.mem_act(mem_act),
		.fetch_cnt(fetch_cnt),
		.fail_cnt(fail_cnt)
	);

	led_ctrl led_ctrl_inst (
		.sw(sw),
		.sel_override(sel_override),
		.override_sel(override_sel),
		.hold(hold),
		.flush(flush),
		.decoder_error(decoder_error),
		.inst_read_done(inst_read_done),
		.if_pc(if_pc),
		.if_inst(if_inst),
		.reg_debug_out(reg_debug_out),
		.mem_act(mem_act),
		.fetch_cnt(fetch_cnt),
		.fail_cnt(fail_cnt),
		.led_data(led_data)
	);

	// Host port, also reads back the LED word
	dbg_apb_regs dbg_apb_regs_inst (
		.clk(clk),
		.reset(reset),
		.paddr(paddr),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.led_data(led_data),
		.sel_override(sel_override),
		.override_sel(override_sel),
		.cnt_clear(cnt_clear)
	);

endmodule

`default_nettype wire

// ==== hdl/event_counters.sv ====
`timescale 1ns/1ps
`default_nettype none

module event_counters (
	input wire clk,
	input wire reset,

	input wire mem_op,
	input wire inst_read_done,
	input wire mem_retry,
	input wire cnt_clear,

	output dbg_pkg::count_t mem_act,
	output dbg_pkg::count_t fetch_cnt,
	output dbg_pkg::count_t fail_cnt
);

	import dbg_pkg::*;

	localparam int NUM_EVENTS = 3;

	logic [NUM_EVENTS-1:0] events;
	count_t [NUM_EVENTS-1:0] cnt;

	// Slot order matches the output order below
	assign events = {mem_retry, inst_read_done, mem_op};

	always_ff @(posedge clk) begin
		if (reset || cnt_clear) begin
			cnt <= '0;
		end else begin
			for (int i = 0; i < NUM_EVENTS; i++) begin
				// Wraps silently at full scale
				if (events[i]) begin
					cnt[i] <= cnt[i] + 1'b1;
				end
			end
		end
	end

	assign mem_act   = cnt[0];
	assign fetch_cnt = cnt[1];
	assign fail_cnt  = cnt[2];

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// Clear beats any event arriving in the same cycle
	clear_zeroes_all: assert property (
		@(posedge clk) disable iff (reset)
		cnt_clear |=> (mem_act == '0 && fetch_cnt == '0 && fail_cnt == '0)
	);

endmodule

`default_nettype wire

// ==== hdl/led_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_settings.svh"

module led_ctrl (
	input wire dbg_pkg::word_t sw,
	input wire sel_override,
	input wire dbg_pkg::view_sel_t override_sel,

	input wire hold,
	input wire flush,
	input wire decoder_error,
	input wire inst_read_done,
	input wire dbg_pkg::word_t if_pc,
	input wire dbg_pkg::word_t if_inst,

	input wire [`DBG_NUM_REGS*$bits(dbg_pkg::word_t)-1:0] reg_debug_out,

	input wire dbg_pkg::count_t mem_act,
	input wire dbg_pkg::count_t fetch_cnt,
	input wire dbg_pkg::count_t fail_cnt,

	output dbg_pkg::word_t led_data
);

	import dbg_pkg::*;

	view_sel_t view_code;
	reg_addr_t reg_idx;
	word_t [`DBG_NUM_REGS-1:0] shadow_words;
	logic [31:0] mem_wide;
	logic [31:0] fail_wide;

	assign view_code = sel_override ? override_sel : sw[15:8];

	// Code 3F is register 0, counting down
	assign reg_idx = reg_addr_t'(VIEW_REG_FIRST - view_code);

	assign shadow_words = reg_debug_out;

	// Counters padded so both halves exist at any width
	assign mem_wide  = 32'(mem_act);
	assign fail_wide = 32'(fail_cnt);

	always_comb begin
		led_data = sw;
		case (view_code)
			VIEW_STATUS: begin
				led_data = {hold, 1'b0, flush, 1'b0, decoder_error, 1'b0,
					inst_read_done, 9'b0};
			end
			VIEW_PC:       led_data = if_pc;
			VIEW_INST:     led_data = if_inst;
			VIEW_MEM_LO:   led_data = mem_wide[15:0];
			VIEW_MEM_HI:   led_data = mem_wide[31:16];
			VIEW_FETCH_LO: led_data = word_t'(fetch_cnt);
			VIEW_FAIL_LO:  led_data = fail_wide[15:0];
			VIEW_FAIL_HI:  led_data = fail_wide[31:16];
			default: begin
				// Shadow slices, anything else keeps the switches
				if (view_code inside {[VIEW_REG_LAST:VIEW_REG_FIRST]} &&
						int'(reg_idx) < `DBG_NUM_REGS) begin
					led_data = shadow_words[reg_idx];
				end
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hdl/reg_shadow.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_settings.svh"

module reg_shadow (
	input wire clk,
	input wire reset,

	input wire reg_writable,
	input wire dbg_pkg::reg_addr_t reg_write_addr,
	input wire dbg_pkg::word_t reg_write_value,

	output logic [`DBG_NUM_REGS*$bits(dbg_pkg::word_t)-1:0] reg_debug_out
);

	import dbg_pkg::*;

	// One word per register, register 0 in the lowest slice
	word_t [`DBG_NUM_REGS-1:0] shadow;

	always_ff @(posedge clk) begin
		if (reset) begin
			shadow <= '0;
		end else if (reg_writable) begin
			// Indexes past the register count are dropped
			if (int'(reg_write_addr) < `DBG_NUM_REGS) begin
				shadow[reg_write_addr] <= reg_write_value;
			end
		end
	end

	assign reg_debug_out = shadow;

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	// A strobed write from the core must carry a known index
	write_addr_known: assert property (
		@(posedge clk) disable iff (reset)
		reg_writable |-> !$isunknown(reg_write_addr)
	);

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	-f vlog.f --top-module dbg_top_tb -o dbg_top_tb

out=$(./obj_dir/dbg_top_tb)
echo "$out"
echo "$out" | grep -q "^Simulation passed$"

// ==== verification/dbg_top_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "dbg_settings.svh"

module dbg_top_tb;

	import dbg_pkg::*;

	localparam int APB_TIMEOUT = 16;

	logic clk = 1'b0;
	logic reset;
	word_t sw;
	word_t led_data;
	logic reg_writable;
	reg_addr_t reg_write_addr;
	word_t reg_write_value;
	word_t if_pc;
	word_t if_inst;
	logic inst_read_done;
	logic mem_op;
	logic mem_retry;
	logic hold;
	logic flush;
	logic decoder_error;
	apb_addr_t paddr;
	logic psel;
	logic penable;
	logic pwrite;
	word_t pwdata;
	word_t prdata;
	logic pready;
	logic pslverr;

	// Reference model state
	word_t shadow_m [`DBG_NUM_REGS];
	count_t mem_m;
	count_t fetch_m;
	count_t fail_m;
	logic clear_pending;
	logic ctrl_en_m;
	view_sel_t ctrl_code_m;

	view_sel_t view_code;
	int reg_idx;
	logic [31:0] mem_w;
	logic [31:0] fail_w;
	word_t expected_led;
	word_t expected_prdata;
	logic bus_access;
	logic illegal;

	string test_name = "reset";
	int led_errors = 0;
	int apb_errors = 0;
	int timeouts = 0;
	logic [31:0] rnd_state = 32'h8a8d_adad;

	dbg_top dbg_top_inst (.*);

	always #5 clk = ~clk;

	////////////////////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////////////////////

	assign bus_access = psel && penable;
	assign illegal = !(paddr inside {APB_CTRL, APB_VIEW, APB_CLEAR}) ||
		(pwrite && paddr == APB_VIEW) || (!pwrite && paddr == APB_CLEAR);
	assign mem_w = 32'(mem_m);
	assign fail_w = 32'(fail_m);

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `DBG_NUM_REGS; i++) begin
				shadow_m[i] <= '0;
			end
			mem_m <= '0;
			fetch_m <= '0;
			fail_m <= '0;
			clear_pending <= 1'b0;
			ctrl_en_m <= 1'b0;
			ctrl_code_m <= '0;
		end else begin
			if (reg_writable && int'(reg_write_addr) < `DBG_NUM_REGS) begin
				shadow_m[reg_write_addr] <= reg_write_value;
			end
			// Clear lands one edge after the CLEAR access
			if (clear_pending) begin
				mem_m <= '0;
				fetch_m <= '0;
				fail_m <= '0;
			end else begin
				mem_m <= mem_m + count_t'(mem_op);
				fetch_m <= fetch_m + count_t'(inst_read_done);
				fail_m <= fail_m + count_t'(mem_retry);
			end
			clear_pending <= bus_access && pwrite && paddr == APB_CLEAR;
			if (bus_access && pwrite && paddr == APB_CTRL) begin
				ctrl_en_m <= pwdata[0];
				ctrl_code_m <= pwdata[15:8];
			end
		end
	end

	always_comb begin
		view_code = ctrl_en_m ? ctrl_code_m : sw[15:8];
		reg_idx = 8'h3F - int'(view_code);
		expected_led = sw;
		case (view_code)
			8'h00: expected_led = {hold, 1'b0, flush, 1'b0, decoder_error, 1'b0,
				inst_read_done, 9'b0};
			8'h0F: expected_led = if_pc;
			8'h10: expected_led = if_inst;
			8'h2D: expected_led = mem_w[15:0];
			8'h2E: expected_led = mem_w[31:16];
			8'h2F: expected_led = fetch_m[15:0];
			8'h48: expected_led = fail_w[15:0];
			8'h49: expected_led = fail_w[31:16];
			default: begin
				if (view_code >= 8'h30 && view_code <= 8'h3F && reg_idx < `DBG_NUM_REGS) begin
					expected_led = shadow_m[reg_idx];
				end
			end
		endcase
		expected_prdata = (paddr == APB_CTRL) ? {ctrl_code_m, 7'b0, ctrl_en_m} : expected_led;
	end

	////////////////////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////////////////////

	led_view_check: assert property (
		@(posedge clk) disable iff (reset)
		led_data == expected_led
	) else begin
		led_errors++;
		$display("error %s: led_data expected %h actual %h", test_name,
			$sampled(expected_led), $sampled(led_data));
	end

	read_data_check: assert property (
		@(posedge clk) disable iff (reset)
		(bus_access && !pwrite && !illegal) |-> prdata == expected_prdata
	) else begin
		apb_errors++;
		$display("error %s: prdata expected %h actual %h", test_name,
			$sampled(expected_prdata), $sampled(prdata));
	end

	// Ready and error flags as one pair {pready, pslverr}
	response_check: assert property (
		@(posedge clk) disable iff (reset)
		pready == bus_access && pslverr == (bus_access && illegal)
	) else begin
		apb_errors++;
		$display("error %s: {pready,pslverr} expected %b actual %b", test_name,
			{$sampled(bus_access), $sampled(bus_access && illegal)},
			{$sampled(pready), $sampled(pslverr)});
	end

	////////////////////////////////////////////////////////////////////////////
	// Stimulus
	////////////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	task automatic apb_transfer(input apb_addr_t addr, input logic write, input word_t data);
		int waited;
		@(negedge clk);
		paddr = addr;
		pwrite = write;
		pwdata = data;
		psel = 1'b1;
		penable = 1'b0;
		@(negedge clk);
		penable = 1'b1;
		waited = 0;
		do begin
			@(posedge clk);
			waited++;
		end while (!pready && waited < APB_TIMEOUT);
		if (!pready) begin
			timeouts++;
			$display("APB transfer at offset %h saw no pready in %0d cycles", addr, waited);
		end
		@(negedge clk);
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
	endtask

	task automatic apb_write(input apb_addr_t addr, input word_t data);
		apb_transfer(addr, 1'b1, data);
	endtask

	task automatic apb_read(input apb_addr_t addr);
		apb_transfer(addr, 1'b0, '0);
	endtask

	task automatic show_view(input view_sel_t code);
		@(negedge clk);
		sw = {code, rnd_state[7:0]};
		rnd_state = xorshift32(rnd_state);
	endtask

	initial begin
		reset = 1'b1;
		sw = '0;
		reg_writable = 1'b0;
		reg_write_addr = '0;
		reg_write_value = '0;
		if_pc = '0;
		if_inst = '0;
		inst_read_done = 1'b0;
		mem_op = 1'b0;
		mem_retry = 1'b0;
		hold = 1'b0;
		flush = 1'b0;
		decoder_error = 1'b0;
		paddr = '0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;

		test_name = "unlisted_code";
		show_view(8'h77);
		show_view(8'hC3);

		test_name = "register_shadow";
		for (int n = 0; n < `DBG_NUM_REGS + 4; n++) begin
			@(negedge clk);
			reg_writable = 1'b1;
			reg_write_addr = reg_addr_t'(n % `DBG_NUM_REGS);
			reg_write_value = rnd_state[15:0];
			rnd_state = xorshift32(rnd_state);
		end
		@(negedge clk);
		reg_writable = 1'b0;
		for (int n = 0; n < `DBG_NUM_REGS; n++) begin
			show_view(view_sel_t'(8'h3F - n));
		end

		test_name = "live_views";
		for (int i = 0; i < 8; i++) begin
			show_view(8'h00);
			{hold, flush, decoder_error, inst_read_done} = rnd_state[3:0];
			if_pc = rnd_state[31:16];
			show_view(8'h0F);
			if_inst = rnd_state[15:0];
			show_view(8'h10);
		end
		{hold, flush, decoder_error, inst_read_done} = 4'b0;

		test_name = "counters";
		for (int i = 0; i < 60; i++) begin
			show_view(8'h2D);
			{mem_retry, inst_read_done, mem_op} = rnd_state[2:0];
		end
		@(negedge clk);
		{mem_retry, inst_read_done, mem_op} = 3'b0;
		show_view(8'h2D);
		show_view(8'h2E);
		show_view(8'h2F);
		show_view(8'h48);
		show_view(8'h49);
		apb_write(APB_CLEAR, 16'h0001);
		show_view(8'h2D);
		show_view(8'h2F);
		show_view(8'h48);
		mem_op = 1'b1;
		show_view(8'h2D);
		mem_op = 1'b0;

		test_name = "override";
		apb_write(APB_CTRL, 16'h3F01);
		for (int i = 0; i < 4; i++) begin
			show_view(view_sel_t'(rnd_state[15:8]));
		end
		apb_read(APB_VIEW);
		apb_read(APB_CTRL);
		apb_write(APB_CTRL, 16'h2D00);
		show_view(8'h10);
		show_view(8'h66);

		test_name = "illegal_access";
		apb_write(APB_CTRL, 16'h2D01);
		apb_write(4'hC, 16'h4801);
		apb_read(4'hC);
		apb_write(APB_VIEW, 16'h0001);
		apb_read(APB_CLEAR);
		apb_read(APB_CTRL);
		apb_read(APB_VIEW);
		apb_write(APB_CTRL, 16'h0000);
		show_view(8'h2D);
		show_view(8'h48);
		repeat (2) @(negedge clk);

		$display("led errors %0d, apb errors %0d, timeouts %0d",
			led_errors, apb_errors, timeouts);
		if (led_errors == 0 && apb_errors == 0 && timeouts == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+hdl
hdl/dbg_pkg.sv
hdl/reg_shadow.sv
hdl/event_counters.sv
hdl/led_ctrl.sv
hdl/dbg_apb_regs.sv
hdl/dbg_top.sv
verification/dbg_top_tb.sv
